// ==== include/marble_defines.svh ====
////////////////////
// Board test build constants, shared by the echo path and the base block
// The echo buffer depth must be a power of two
////////////////////

`ifndef MARBLE_DEFINES_SVH
`define MARBLE_DEFINES_SVH

// Bytes held by the echo buffer, after preamble and SFD
`define MARBLE_FRAME_DEPTH 64

// EtherType that carries the external configuration nibble
`define MARBLE_CONFIG_ETHERTYPE 16'h88B5

// tx_clk cycles of PHY reset after the clocks lock
`define MARBLE_PHY_RST_CYCLES 32

`endif

// ==== rtl/marble_pkg.sv ====
////////////////////
// Bus and configuration types for the board test build
////////////////////

package marble_pkg;

	// One GMII beat, used for both directions
	typedef struct packed {
		logic [7:0] data;
		logic en;
		logic er;
	} gmii_bus_t;

	// One RGMII pin set, sampled on a single clock edge
	typedef struct packed {
		logic [3:0] data;
		logic ctl;
	} rgmii_bus_t;

	// Field view of the configuration nibble
	typedef struct packed {
		logic [1:0] reserved;
		logic vcxo_off;
		logic tmds_enable;
	} ext_config_fields_t;

	// Raw view goes to the LEDs, field view to the board controls
	typedef union packed {
		logic [3:0] raw;
		ext_config_fields_t fields;
	} ext_config_t;

endpackage

// ==== rtl/gmii_to_rgmii.sv ====
////////////////////
// Receive clock must match tx_clk in frequency and phase
////////////////////

`timescale 1ns/1ps

module gmii_to_rgmii #(
	parameter bit in_phase_tx_clk = 1'b1
) (
	input logic tx_clk,
	input logic tx_clk90,
	input logic reset,
	input marble_pkg::gmii_bus_t gmii_tx,
	output marble_pkg::gmii_bus_t gmii_rx,
	output marble_pkg::rgmii_bus_t rgmii_tx,
	output logic rgmii_tx_clk,
	input marble_pkg::rgmii_bus_t rgmii_rx,
	input logic rgmii_rx_clk
);

	marble_pkg::rgmii_bus_t tx_rise;
	marble_pkg::rgmii_bus_t tx_hold;
	marble_pkg::rgmii_bus_t tx_fall;
	marble_pkg::rgmii_bus_t rx_rise;
	marble_pkg::rgmii_bus_t rx_fall;

	// Both halves of the byte are taken on the rising edge
	always_ff @(posedge tx_clk) begin
		if (reset) begin
			tx_rise <= '0;
			tx_hold <= '0;
		end else begin
			tx_rise <= '{data: gmii_tx.data[3:0], ctl: gmii_tx.en};
			tx_hold <= '{data: gmii_tx.data[7:4], ctl: gmii_tx.en ^ gmii_tx.er};
		end
	end

	// High nibble moves to the falling-edge register half a cycle later
	always_ff @(negedge tx_clk) begin
		if (reset)
			tx_fall <= '0;
		else
			tx_fall <= tx_hold;
	end

	// DDR output stage, clock level picks the edge register
	assign rgmii_tx = tx_clk ? tx_rise : tx_fall;
	assign rgmii_tx_clk = in_phase_tx_clk ? tx_clk : tx_clk90;

	always_ff @(posedge rgmii_rx_clk) begin
		rx_rise <= rgmii_rx;
	end

	always_ff @(negedge rgmii_rx_clk) begin
		rx_fall <= rgmii_rx;
	end

	// Rebuild on tx_clk; rx_rise still holds the beat paired with rx_fall
	always_ff @(posedge tx_clk) begin
		if (reset)
			gmii_rx <= '0;
		else
			gmii_rx <= '{data: {rx_fall.data, rx_rise.data}, en: rx_rise.ctl,
				er: rx_rise.ctl ^ rx_fall.ctl};
	end

	// Pin ctl is quiet once reset has been held
	tx_ctl_quiet_in_reset: assert property (
		@(posedge tx_clk) reset && $past(reset) |-> !rgmii_tx.ctl
	);

endmodule

// ==== rtl/frame_echo.sv ====
////////////////////
// No back-pressure: frames arriving during an echo are dropped
// Configuration frames need at least 15 bytes after the SFD
////////////////////

`timescale 1ns/1ps

`include "marble_defines.svh"

module frame_echo (
	input logic tx_clk,
	input logic reset,
	input marble_pkg::gmii_bus_t rx,
	output marble_pkg::gmii_bus_t tx,
	output logic config_load,
	output marble_pkg::ext_config_t config_word,
	output logic [3:0] echo_count
);

	localparam int DEPTH = `MARBLE_FRAME_DEPTH;
	localparam int AW = $clog2(DEPTH);
	localparam int PW = AW + 1;
	localparam int OW = $clog2(DEPTH + 9);

	logic [7:0] buffer [DEPTH];
	logic rx_en_d;
	logic [3:0] pre_cnt;
	logic bad;
	logic [PW-1:0] wr_ptr;
	logic [15:0] eth_type;
	marble_pkg::ext_config_t cfg_word;
	logic [7:0] pre_byte;
	logic wr_en;
	logic frame_end;
	logic good;
	logic is_cfg;
	logic start_echo;
	logic busy;
	logic go;
	logic tx_active;
	logic [PW-1:0] tx_len;
	logic [OW-1:0] out_idx;
	logic [AW-1:0] rd_addr;

	assign pre_byte = (pre_cnt == 4'd7) ? 8'hD5 : 8'h55;
	assign wr_en = rx.en && rx_en_d && pre_cnt == 4'd8 && !rx.er && !bad
		&& wr_ptr != PW'(DEPTH);
	assign frame_end = rx_en_d && !rx.en;
	assign good = !bad && pre_cnt == 4'd8;
	assign is_cfg = eth_type == `MARBLE_CONFIG_ETHERTYPE && wr_ptr > PW'(14);
	assign start_echo = frame_end && good && !is_cfg && wr_ptr != '0;
	assign busy = go || tx_active;
	assign config_load = frame_end && good && is_cfg;
	assign config_word = cfg_word;
	assign rd_addr = AW'(out_idx - OW'(8));

	// Receive side: preamble check, byte count, drop decision
	always_ff @(posedge tx_clk) begin
		if (reset) begin
			rx_en_d <= 1'b0;
			pre_cnt <= '0;
			bad <= 1'b0;
			wr_ptr <= '0;
		end else begin
			rx_en_d <= rx.en;
			if (rx.en && !rx_en_d) begin
				pre_cnt <= 4'd1;
				wr_ptr <= '0;
				bad <= busy || rx.er || rx.data != 8'h55;
			end else if (rx.en && pre_cnt != 4'd8) begin
				pre_cnt <= pre_cnt + 4'd1;
				if (rx.er || rx.data != pre_byte)
					bad <= 1'b1;
			end else if (rx.en) begin
				// Error, overflow, or already dropped
				if (wr_en)
					wr_ptr <= wr_ptr + 1'b1;
				else
					bad <= 1'b1;
			end
		end
	end

	// Frame store; bytes 12 to 14 also feed the configuration decode
	always_ff @(posedge tx_clk) begin
		if (wr_en) begin
			buffer[wr_ptr[AW-1:0]] <= rx.data;
			if (wr_ptr == PW'(12))
				eth_type[15:8] <= rx.data;
			if (wr_ptr == PW'(13))
				eth_type[7:0] <= rx.data;
			if (wr_ptr == PW'(14))
				cfg_word.raw <= rx.data[3:0];
		end
		if (start_echo)
			tx_len <= wr_ptr;
	end

	// Replay: fresh preamble and SFD, then the stored bytes
	always_ff @(posedge tx_clk) begin
		if (reset) begin
			go <= 1'b0;
			tx_active <= 1'b0;
			out_idx <= '0;
			tx <= '0;
			echo_count <= '0;
		end else begin
			go <= start_echo;
			if (go) begin
				tx <= '{data: 8'h55, en: 1'b1, er: 1'b0};
				out_idx <= OW'(1);
				tx_active <= 1'b1;
			end else if (tx_active) begin
				if (out_idx == OW'(tx_len) + OW'(8)) begin
					tx <= '0;
					tx_active <= 1'b0;
					echo_count <= echo_count + 4'd1;
				end else begin
					if (out_idx < OW'(7))
						tx.data <= 8'h55;
					else if (out_idx == OW'(7))
						tx.data <= 8'hD5;
					else
						tx.data <= buffer[rd_addr];
					out_idx <= out_idx + 1'b1;
				end
			end
		end
	end

	wr_ptr_in_range: assert property (
		@(posedge tx_clk) disable iff (reset) wr_ptr <= PW'(DEPTH)
	);

	// Echoed frames never carry an error
	tx_er_never: assert property (
		@(posedge tx_clk) disable iff (reset) !tx.er
	);

endmodule

// ==== rtl/marble_base.sv ====
////////////////////
// Echo path stays in reset until PHY_RSTN is released
////////////////////

`timescale 1ns/1ps

`include "marble_defines.svh"

module marble_base (
	input logic tx_clk,
	input logic reset,
	input logic clk_locked,
	input marble_pkg::gmii_bus_t gmii_rx,
	output marble_pkg::gmii_bus_t gmii_tx,
	output logic phy_rstn,
	output marble_pkg::ext_config_t ext_config,
	output logic vcxo_en,
	output logic [7:0] led
);

	localparam int RST_CYCLES = `MARBLE_PHY_RST_CYCLES;
	localparam int CW = $clog2(RST_CYCLES + 1);

	logic [CW-1:0] rst_cnt;
	logic echo_reset;
	logic config_load;
	marble_pkg::ext_config_t config_word;
	logic [3:0] echo_count;

	// Count starts on the first locked sample, then runs to the hold time
	always_ff @(posedge tx_clk) begin
		if (reset) begin
			rst_cnt <= '0;
			phy_rstn <= 1'b0;
		end else if (!phy_rstn) begin
			if (rst_cnt == CW'(RST_CYCLES))
				phy_rstn <= 1'b1;
			else if (rst_cnt != '0 || clk_locked)
				rst_cnt <= rst_cnt + 1'b1;
		end
	end

	always_ff @(posedge tx_clk) begin
		if (reset)
			ext_config <= '0;
		else if (config_load)
			ext_config <= config_word;
	end

	assign echo_reset = reset || !phy_rstn;

	frame_echo echo (
		.tx_clk(tx_clk),
		.reset(echo_reset),
		.rx(gmii_rx),
		.tx(gmii_tx),
		.config_load(config_load),
		.config_word(config_word),
		.echo_count(echo_count)
	);

	assign led = {ext_config.raw, echo_count};
	assign vcxo_en = ~ext_config.fields.vcxo_off;

	// Nothing goes out to a PHY that is still held in reset
	no_tx_in_phy_reset: assert property (
		@(posedge tx_clk) disable iff (reset) !phy_rstn |-> !gmii_tx.en
	);

endmodule

// ==== rtl/tmds_test.sv ====
////////////////////
// enable crosses into clk through a single flop
////////////////////

`timescale 1ns/1ps

module tmds_test (
	input logic clk,
	input logic reset,
	input logic enable,
	output logic [3:0] tmds_p,
	output logic [3:0] tmds_n
);

	// Control period symbol, C1 C0 = 00
	localparam logic [9:0] CTL_SYM = 10'b1101010100;
	// Pixel clock lane, five ones then five zeros
	localparam logic [9:0] CLK_SYM = 10'b1111100000;

	logic en_sync;
	logic [3:0] bit_idx;
	logic [3:0] lane_bits;

	always_ff @(posedge clk) begin
		if (reset) begin
			en_sync <= 1'b0;
			bit_idx <= '0;
			lane_bits <= '0;
		end else begin
			en_sync <= enable;
			if (en_sync) begin
				// LSB first on every lane
				lane_bits <= {CLK_SYM[bit_idx], {3{CTL_SYM[bit_idx]}}};
				bit_idx <= (bit_idx == 4'd9) ? 4'd0 : bit_idx + 4'd1;
			end else begin
				lane_bits <= '0;
				bit_idx <= '0;
			end
		end
	end

	assign tmds_p = lane_bits;
	assign tmds_n = ~lane_bits;

endmodule

// ==== rtl/marble_top.sv ====
////////////////////
// Clocks and lock come in from outside; no vendor primitives here
////////////////////

`timescale 1ns/1ps

module marble_top #(
	parameter bit in_phase_tx_clk = 1'b1
) (
	input logic tx_clk,
	input logic tx_clk90,
	input logic test_clk,
	input logic reset,
	input logic clk_locked,
	output logic [3:0] RGMII_TXD,
	output logic RGMII_TX_CTRL,
	output logic RGMII_TX_CLK,
	input logic [3:0] RGMII_RXD,
	input logic RGMII_RX_CTRL,
	input logic RGMII_RX_CLK,
	output logic PHY_RSTN,
	output logic VCXO_EN,
	output logic [3:0] TMDS_P,
	output logic [3:0] TMDS_N,
	output logic [7:0] Pmod1
);

	marble_pkg::rgmii_bus_t rgmii_tx;
	marble_pkg::rgmii_bus_t rgmii_rx;
	marble_pkg::gmii_bus_t gmii_tx;
	marble_pkg::gmii_bus_t gmii_rx;
	marble_pkg::ext_config_t ext_config;

	assign RGMII_TXD = rgmii_tx.data;
	assign RGMII_TX_CTRL = rgmii_tx.ctl;
	assign rgmii_rx = '{data: RGMII_RXD, ctl: RGMII_RX_CTRL};

	gmii_to_rgmii #(.in_phase_tx_clk(in_phase_tx_clk)) rgmii (
		.tx_clk(tx_clk), .tx_clk90(tx_clk90), .reset(reset),
		.gmii_tx(gmii_tx), .gmii_rx(gmii_rx),
		.rgmii_tx(rgmii_tx), .rgmii_tx_clk(RGMII_TX_CLK),
		.rgmii_rx(rgmii_rx), .rgmii_rx_clk(RGMII_RX_CLK)
	);

	marble_base base (
		.tx_clk(tx_clk), .reset(reset), .clk_locked(clk_locked),
		.gmii_rx(gmii_rx), .gmii_tx(gmii_tx), .phy_rstn(PHY_RSTN),
		.ext_config(ext_config), .vcxo_en(VCXO_EN), .led(Pmod1)
	);

	// Test pattern on the TMDS connector
	tmds_test tmds (
		.clk(test_clk), .reset(reset), .enable(ext_config.fields.tmds_enable),
		.tmds_p(TMDS_P), .tmds_n(TMDS_N)
	);

endmodule

// ==== bench/marble_tb.sv ====
////////////////////
// RGMII receive clock is tx_clk itself, so received beats are in phase with transmit
////////////////////

`timescale 1ns/1ps

`include "marble_defines.svh"

module marble_tb;

	logic tx_clk;
	logic tx_clk90;
	logic test_clk;
	logic reset;
	logic clk_locked;
	logic [3:0] RGMII_TXD;
	logic RGMII_TX_CTRL;
	logic RGMII_TX_CLK;
	logic [3:0] RGMII_RXD;
	logic RGMII_RX_CTRL;
	logic PHY_RSTN;
	logic VCXO_EN;
	logic [3:0] TMDS_P;
	logic [3:0] TMDS_N;
	logic [7:0] Pmod1;

	logic [1:0] phase;
	logic [31:0] rng;
	int errors;
	int checks;
	logic [7:0] send_q[$];
	logic [7:0] expect_q[$];
	logic [7:0] echo_q[$];
	logic [3:0] echo_total;
	logic rise_ctl;
	logic last_clk_bit;
	logic clk_fell_seen;
	int run_len;
	int n;

	marble_top #(.in_phase_tx_clk(1'b1)) i_dut (
		.tx_clk(tx_clk), .tx_clk90(tx_clk90), .test_clk(test_clk),
		.reset(reset), .clk_locked(clk_locked),
		.RGMII_TXD(RGMII_TXD), .RGMII_TX_CTRL(RGMII_TX_CTRL), .RGMII_TX_CLK(RGMII_TX_CLK),
		.RGMII_RXD(RGMII_RXD), .RGMII_RX_CTRL(RGMII_RX_CTRL), .RGMII_RX_CLK(tx_clk),
		.PHY_RSTN(PHY_RSTN), .VCXO_EN(VCXO_EN),
		.TMDS_P(TMDS_P), .TMDS_N(TMDS_N), .Pmod1(Pmod1)
	);

	// 10 ns steps: tx_clk high in phases 0 and 1, tx_clk90 in phases 1 and 2
	always begin
		#10;
		phase = phase + 2'd1;
		tx_clk = phase == 2'd0 || phase == 2'd1;
		tx_clk90 = phase == 2'd1 || phase == 2'd2;
		test_clk = phase[0];
	end

	// tx_clk90 edges fall in the middle of each RGMII half cycle
	always @(posedge tx_clk90)
		rise_ctl <= RGMII_TX_CTRL;

	// Run length of the TMDS clock lane, one sample per test_clk
	always @(posedge test_clk) begin
		if (TMDS_P[3] == last_clk_bit)
			run_len <= run_len + 1;
		else
			run_len <= 1;
		if (last_clk_bit && !TMDS_P[3])
			clk_fell_seen <= 1'b1;
		last_clk_bit <= TMDS_P[3];
	end

	// Both ctl halves equal means er is never sent
	ctl_both_edges: assert property (
		@(negedge tx_clk90) disable iff (reset) RGMII_TX_CTRL == rise_ctl
	) else begin
		errors++;
		$display("** Error at time %0t: RGMII_TX_CTRL = %b, expected %b", $time,
			$sampled(RGMII_TX_CTRL), $sampled(rise_ctl));
	end

	// test_clk rises in the middle of both tx_clk half cycles
	tx_clk_forwarded: assert property (
		@(posedge test_clk) RGMII_TX_CLK == tx_clk
	) else begin
		errors++;
		$display("** Error at time %0t: RGMII_TX_CLK = %b, expected %b", $time,
			$sampled(RGMII_TX_CLK), $sampled(tx_clk));
	end

	quiet_in_phy_reset: assert property (
		@(negedge tx_clk90) disable iff (reset) !PHY_RSTN |-> !RGMII_TX_CTRL
	) else begin
		errors++;
		$display("** Error at time %0t: RGMII_TX_CTRL = 1, expected 0", $time);
	end

	tmds_complement: assert property (
		@(posedge test_clk) disable iff (reset) TMDS_N == ~TMDS_P
	) else begin
		errors++;
		$display("** Error at time %0t: TMDS_N = %h, expected %h", $time,
			$sampled(TMDS_N), ~$sampled(TMDS_P));
	end

	// First rise is skipped since idle zeros run into the first zero half
	clk_lane_runs: assert property (
		@(posedge test_clk) disable iff (reset)
		TMDS_P[3] != last_clk_bit && (last_clk_bit || clk_fell_seen) |-> run_len == 5
	) else begin
		errors++;
		$display("** Error at time %0t: TMDS_P[3] run = %0d, expected 5", $time,
			$sampled(run_len));
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("** Error at time %0t: %s = %0h, expected %0h", $time, name, actual,
				expected);
		end
	endtask

	// Low nibble set up for the rising edge, high nibble for the falling edge
	task automatic drive_rx_beat(input logic [7:0] d, input logic en, input logic er);
		RGMII_RXD = d[3:0];
		RGMII_RX_CTRL = en;
		@(posedge tx_clk);
		#2;
		RGMII_RXD = d[7:4];
		RGMII_RX_CTRL = en ^ er;
		@(negedge tx_clk);
		#2;
	endtask

	task automatic build_frame(input int len);
		int i;
		send_q.delete();
		repeat (7) send_q.push_back(8'h55);
		send_q.push_back(8'hD5);
		for (i = 0; i < len; i++) begin
			rng = xorshift32(rng);
			send_q.push_back(rng[7:0]);
		end
		// Keep the EtherType away from the configuration value
		send_q[20] = 8'h08;
	endtask

	task automatic send_frame(input int er_at);
		int i;
		@(negedge tx_clk);
		#2;
		for (i = 0; i < send_q.size(); i++)
			drive_rx_beat(send_q[i], 1'b1, i == er_at);
		RGMII_RXD = 4'h0;
		RGMII_RX_CTRL = 1'b0;
	endtask

	task automatic capture_frame();
		int i;
		logic [3:0] lo;
		logic seen;
		seen = 1'b0;
		echo_q.delete();
		for (i = 0; i < 200 && !seen; i++) begin
			@(posedge tx_clk90);
			seen = RGMII_TX_CTRL;
		end
		if (!seen) begin
			errors++;
			$display("No echo appeared on the RGMII tx pins within 200 cycles");
		end else begin
			i = 0;
			while (RGMII_TX_CTRL && i < 2 * `MARBLE_FRAME_DEPTH) begin
				lo = RGMII_TXD;
				@(negedge tx_clk90);
				echo_q.push_back({RGMII_TXD, lo});
				@(posedge tx_clk90);
				i++;
			end
			if (RGMII_TX_CTRL) begin
				errors++;
				$display("Echoed frame did not end within %0d bytes", i);
			end
		end
	endtask

	task automatic compare_echo();
		int i;
		check_value("echo length", echo_q.size(), expect_q.size());
		for (i = 0; i < expect_q.size() && i < echo_q.size(); i++)
			check_value($sformatf("echo byte %0d", i), echo_q[i], expect_q[i]);
	endtask

	task automatic expect_no_echo(input int cycles);
		int i;
		checks++;
		for (i = 0; i < cycles; i++) begin
			@(posedge tx_clk90);
			if (RGMII_TX_CTRL) begin
				errors++;
				$display("Unexpected frame on the RGMII tx pins at time %0t", $time);
				break;
			end
		end
	endtask

	initial begin
		phase = 2'd3;
		tx_clk = 1'b0;
		tx_clk90 = 1'b0;
		test_clk = 1'b0;
		reset = 1'b1;
		clk_locked = 1'b0;
		RGMII_RXD = 4'h0;
		RGMII_RX_CTRL = 1'b0;
		rng = 32'h4260a38f;
		errors = 0;
		checks = 0;
		echo_total = 4'd0;
		rise_ctl = 1'b0;
		last_clk_bit = 1'b0;
		clk_fell_seen = 1'b0;
		run_len = 0;
		repeat (16) @(posedge tx_clk);
		#2;
		reset = 1'b0;
		check_value("PHY_RSTN", PHY_RSTN, 1'b0);
		check_value("RGMII_TX_CTRL", RGMII_TX_CTRL, 1'b0);
		check_value("VCXO_EN", VCXO_EN, 1'b1);
		check_value("TMDS_P", TMDS_P, 4'h0);
		check_value("TMDS_N", TMDS_N, 4'hF);

		// A good frame sent before the lock must not come back
		build_frame(20);
		send_frame(-1);
		expect_no_echo(20);

		// PHY reset hold counted from the first edge that sees the lock
		@(posedge tx_clk);
		#2;
		clk_locked = 1'b1;
		@(posedge tx_clk);
		n = 0;
		while (!PHY_RSTN && n < 4 * `MARBLE_PHY_RST_CYCLES) begin
			@(posedge tx_clk);
			#1;
			n++;
		end
		if (!PHY_RSTN)
			$display("PHY_RSTN was never released after clk_locked");
		check_value("PHY_RSTN delay", n, `MARBLE_PHY_RST_CYCLES);

		// Good random frame is echoed unchanged
		rng = xorshift32(rng);
		build_frame(20 + rng % 41);
		expect_q = send_q;
		send_frame(-1);
		capture_frame();
		compare_echo();
		echo_total++;
		check_value("Pmod1[3:0]", Pmod1[3:0], echo_total);

		// Frames that must be dropped
		build_frame(30);
		send_frame(25);
		expect_no_echo(150);
		check_value("Pmod1[3:0]", Pmod1[3:0], echo_total);
		build_frame(`MARBLE_FRAME_DEPTH + 6);
		send_frame(-1);
		expect_no_echo(150);
		check_value("Pmod1[3:0]", Pmod1[3:0], echo_total);

		// Second frame lands while the first is being echoed
		build_frame(40);
		expect_q = send_q;
		fork
			begin
				send_frame(-1);
				repeat (6) drive_rx_beat(8'h00, 1'b0, 1'b0);
				build_frame(20);
				send_frame(-1);
			end
			capture_frame();
		join
		compare_echo();
		expect_no_echo(150);
		echo_total++;
		check_value("Pmod1[3:0]", Pmod1[3:0], echo_total);

		// Configuration frame, nibble 3 sets vcxo_off and tmds_enable
		build_frame(20);
		send_q[20] = 8'(`MARBLE_CONFIG_ETHERTYPE >> 8);
		send_q[21] = 8'(`MARBLE_CONFIG_ETHERTYPE);
		send_q[22] = 8'hA3;
		send_frame(-1);
		expect_no_echo(150);
		check_value("Pmod1[7:4]", Pmod1[7:4], 4'h3);
		check_value("Pmod1[3:0]", Pmod1[3:0], echo_total);
		check_value("VCXO_EN", VCXO_EN, 1'b0);
		n = 0;
		while (!TMDS_P[3] && n < 30) begin
			@(negedge test_clk);
			n++;
		end
		if (!TMDS_P[3]) begin
			errors++;
			$display("TMDS clock lane did not start toggling");
		end
		repeat (60) @(posedge test_clk);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+include
rtl/marble_pkg.sv
rtl/gmii_to_rgmii.sv
rtl/frame_echo.sv
rtl/marble_base.sv
rtl/tmds_test.sv
rtl/marble_top.sv
bench/marble_tb.sv

// ==== Bender.yml ====
package:
  name: marble_test

sources:
  - include_dirs:
      - include
    files:
      - rtl/marble_pkg.sv
      - rtl/gmii_to_rgmii.sv
      - rtl/frame_echo.sv
      - rtl/marble_base.sv
      - rtl/tmds_test.sv
      - rtl/marble_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/marble_tb.sv
